//--- hw/board_top.sv
// board top: reset stretcher and the serial command path wired to the pins
`timescale 1ns/1ps

module board_top (
  input  logic       clk_25mhz,
  input  logic       rst,
  input  logic       uart_rx_line,
  output logic       uart_tx_line,
  output logic [7:0] leds
);

  import uart_pkg::*;

  logic       sys_rst;
  logic       rx_valid;
  rx_beat_t   rx_beat;
  logic       deq_valid;
  rx_beat_t   deq_beat;
  logic       deq_ready;
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       tx_ready;

  // button bounce is filtered here, everything else runs on sys_rst
  reset_gen i_reset_gen (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .sys_rst   (sys_rst)
  );

  uart_rx i_uart_rx (
    .clk_25mhz (clk_25mhz),
    .rst       (sys_rst),
    .rx_line   (uart_rx_line),
    .rx_valid  (rx_valid),
    .rx_beat   (rx_beat)
  );

  byte_fifo i_byte_fifo (
    .clk_25mhz (clk_25mhz),
    .rst       (sys_rst),
    .wr_valid  (rx_valid),
    .wr_beat   (rx_beat),
    .deq_valid (deq_valid),
    .deq_beat  (deq_beat),
    .deq_ready (deq_ready)
  );

  cmd_dispatch i_cmd_dispatch (
    .clk_25mhz (clk_25mhz),
    .rst       (sys_rst),
    .deq_valid (deq_valid),
    .deq_beat  (deq_beat),
    .deq_ready (deq_ready),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_ready  (tx_ready),
    .leds      (leds)
  );

  uart_tx i_uart_tx (
    .clk_25mhz (clk_25mhz),
    .rst       (sys_rst),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_ready  (tx_ready),
    .tx_line   (uart_tx_line)
  );

endmodule

//--- hw/byte_fifo.sv
// receive buffer: circular FIFO of beats with a valid/ready read side
`timescale 1ns/1ps
`include "uart_consts.svh"

module byte_fifo #(
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  logic               clk_25mhz,
  input  logic               rst,
  input  logic               wr_valid,
  input  uart_pkg::rx_beat_t wr_beat,
  output logic               deq_valid,
  output uart_pkg::rx_beat_t deq_beat,
  input  logic               deq_ready
);

  import uart_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rx_beat_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;
  logic            full;
  logic            wr_en;
  logic            rd_en;

  assign full      = (count == (AW+1)'(DEPTH));
  // receiver cannot wait, so a beat against a full buffer is lost
  assign wr_en     = wr_valid && !full;
  assign rd_en     = deq_valid && deq_ready;
  assign deq_valid = (count != '0);
  assign deq_beat  = mem[rd_ptr];

  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // both at once leaves the count alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  a_count_bound : assert property (
    @(posedge clk_25mhz) disable iff (rst)
    count <= (AW+1)'(DEPTH)
  );

  // head must hold while the dispatcher waits on the transmitter
  a_head_stable : assert property (
    @(posedge clk_25mhz) disable iff (rst)
    deq_valid && !deq_ready |=> $stable(deq_beat)
  );

endmodule

//--- hw/cmd_dispatch.sv
// command dispatcher: applies LED commands and echoes characters to the transmitter
`timescale 1ns/1ps
`include "uart_consts.svh"

module cmd_dispatch (
  input  logic               clk_25mhz,
  input  logic               rst,
  input  logic               deq_valid,
  input  uart_pkg::rx_beat_t deq_beat,
  output logic               deq_ready,
  output logic               tx_valid,
  output logic [7:0]         tx_data,
  input  logic               tx_ready,
  output logic [7:0]         leds
);

  import uart_pkg::*;

  localparam logic [1:0] OP_SET_LOW  = 2'd0;
  localparam logic [1:0] OP_SET_HIGH = 2'd1;
  localparam logic [1:0] OP_INVERT   = 2'd2;
  localparam logic [1:0] OP_CLEAR    = 2'd3;

  cmd_word_t head;
  logic      is_cmd;
  logic      take_char;

  assign head   = deq_beat.word;
  // a damaged frame is never trusted as a command
  assign is_cmd = !deq_beat.frame_err && head.cmd.flag;

  // commands drain at once, characters wait for a free transmitter
  assign deq_ready = is_cmd || (tx_ready && !tx_valid);
  assign take_char = deq_valid && !is_cmd && tx_ready && !tx_valid;

  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      tx_valid <= 1'b0;
      leds     <= '0;
    end else begin
      if (tx_valid && tx_ready) begin
        tx_valid <= 1'b0;
      end
      if (take_char) begin
        tx_valid <= 1'b1;
      end
      if (deq_valid && is_cmd) begin
        case (head.cmd.opcode)
          OP_SET_LOW:  leds[3:0] <= head.cmd.arg[3:0];
          OP_SET_HIGH: leds[7:4] <= head.cmd.arg[3:0];
          OP_INVERT:   leds      <= ~leds;
          OP_CLEAR:    leds      <= '0;
          default:     leds      <= leds;
        endcase
      end
    end
  end

  // echo or complain about the framing
  always_ff @(posedge clk_25mhz) begin
    if (take_char) begin
      tx_data <= deq_beat.frame_err ? `UART_REPLY_BAD : head.ch;
    end
  end

  a_tx_hold : assert property (
    @(posedge clk_25mhz) disable iff (rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
  );

endmodule

//--- hw/reset_gen.sv
// reset stretcher: holds the internal reset for a fixed time after the button releases
`timescale 1ns/1ps
`include "uart_consts.svh"

module reset_gen (
  input  logic clk_25mhz,
  input  logic rst,
  output logic sys_rst
);

  localparam int STRETCH = `UART_RST_STRETCH;

  logic [STRETCH-1:0] rst_sr;

  // reload with ones while the button is held, drain zeros in from the top after
  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      rst_sr <= '1;
    end else begin
      rst_sr <= {1'b0, rst_sr[STRETCH-1:1]};
    end
  end

  // last stage drives the rest of the design
  assign sys_rst = rst_sr[0];

endmodule

//--- hw/uart_consts.svh
// uart constants for the serial command block: timing, buffer depth and reply code
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// board oscillator
`define UART_CLK_HZ 25000000

// fixed line rate
`define UART_BAUD 115200

// 217 clocks per bit at 25 MHz
`define UART_CLKS_PER_BIT (`UART_CLK_HZ / `UART_BAUD)

// receive buffer entries
`define UART_FIFO_DEPTH 8

// cycles the internal reset outlasts the button
`define UART_RST_STRETCH 16

// answer to a frame with a bad stop bit
`define UART_REPLY_BAD 8'h3f

`endif

//--- hw/uart_pkg.sv
// uart types: received byte views and the receive beat
package uart_pkg;

  // command view of a byte with bit 7 set
  typedef struct packed {
    logic       flag;
    logic [1:0] opcode;
    logic [4:0] arg;
  } cmd_fields_t;

  // one received byte, read either as ascii or as a command
  typedef union packed {
    logic [7:0]  ch;
    cmd_fields_t cmd;
  } cmd_word_t;

  // what the receiver hands to the buffer per frame
  typedef struct packed {
    cmd_word_t word;
    logic      frame_err;
  } rx_beat_t;

endpackage

//--- hw/uart_rx.sv
// uart receiver: samples the line at mid-bit and emits one beat per 8N1 frame
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx (
  input  logic              clk_25mhz,
  input  logic              rst,
  input  logic              rx_line,
  output logic              rx_valid,
  output uart_pkg::rx_beat_t rx_beat
);

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int HALF = CLKS / 2;
  localparam int CW   = $clog2(CLKS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t      state;
  logic [CW-1:0]  clk_cnt;
  logic [2:0]     bit_idx;
  logic [7:0]     shift_reg;
  logic           rx_meta;
  logic           rx_sync;
  logic           rx_prev;
  logic           bit_tick;

  // middle of a data or stop bit
  assign bit_tick = (clk_cnt == CW'(CLKS - 1));

  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      // idle line is high
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= ST_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta  <= rx_line;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          // falling edge only, so a low stop bit cannot retrigger
          if (rx_prev && !rx_sync) begin
            state   <= ST_START;
            clk_cnt <= '0;
          end
        end
        ST_START: begin
          if (clk_cnt == CW'(HALF - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // glitch, not a start bit
            state   <= rx_sync ? ST_IDLE : ST_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= ST_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_tick) begin
            clk_cnt  <= '0;
            state    <= ST_IDLE;
            rx_valid <= 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // payload path, lsb arrives first
  always_ff @(posedge clk_25mhz) begin
    if (state == ST_DATA && bit_tick) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
    if (state == ST_STOP && bit_tick) begin
      rx_beat.word.ch  <= shift_reg;
      rx_beat.frame_err <= !rx_sync;
    end
  end

endmodule

//--- hw/uart_tx.sv
// uart transmitter: takes one byte by valid/ready and shifts out an 8N1 frame
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx (
  input  logic       clk_25mhz,
  input  logic       rst,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       tx_line
);

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS);

  logic          busy;
  logic [CW-1:0] clk_cnt;
  logic [3:0]    bit_cnt;
  logic [9:0]    frame;
  logic          bit_done;

  assign tx_ready = !busy;
  assign bit_done = (clk_cnt == CW'(CLKS - 1));

  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_line <= 1'b1;
    end else begin
      // line follows the frame one cycle behind the handshake
      tx_line <= busy ? frame[0] : 1'b1;
      if (!busy) begin
        if (tx_valid) begin
          busy    <= 1'b1;
          clk_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (bit_done) begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
        // stop bit was the tenth
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // stop, data, start from msb to lsb
  always_ff @(posedge clk_25mhz) begin
    if (!busy && tx_valid) begin
      frame <= {1'b1, tx_data, 1'b0};
    end else if (busy && bit_done) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the serial command testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_board_top -o sim_tb

# the log decides pass or fail, so the exit status of the run is not used here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
grep -q "Regression passed" sim.log

//--- sim/tb_board_top.sv
// testbench for the serial command block with a byte table, serial driver, monitor and watchdog
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_board_top;

  localparam int CLKS        = `UART_CLKS_PER_BIT;
  localparam int N_ROWS      = 10;
  localparam int N_BURST     = 8;
  localparam int QUIET       = 12 * CLKS;
  localparam int WATCHDOG_NS = 3 * (N_ROWS + N_BURST) * 10 * CLKS * 40;

  logic        clk_25mhz = 1'b0;
  logic        rst;
  logic        uart_rx_line;
  logic        uart_tx_line;
  logic [7:0]  leds;

  // one row per test with name, byte sent, bad stop bit, leds after and byte echoed
  string       row_name  [N_ROWS];
  logic [7:0]  row_byte  [N_ROWS];
  bit          row_bad   [N_ROWS];
  logic [7:0]  row_leds  [N_ROWS];
  logic [7:0]  row_reply [N_ROWS];

  logic [7:0]  echo_q[$];
  logic [7:0]  burst_q[$];
  logic [31:0] lfsr   = 32'hbb03;
  int          errors = 0;
  bit          mon_en = 1'b0;

  board_top i_dut (
    .clk_25mhz    (clk_25mhz),
    .rst          (rst),
    .uart_rx_line (uart_rx_line),
    .uart_tx_line (uart_tx_line),
    .leds         (leds)
  );

  always #20 clk_25mhz = ~clk_25mhz;

  task automatic set_row(input int idx, input string name, input logic [7:0] data,
                         input bit bad, input logic [7:0] exp_leds, input logic [7:0] exp_reply);
    row_name[idx]  = name;
    row_byte[idx]  = data;
    row_bad[idx]   = bad;
    row_leds[idx]  = exp_leds;
    row_reply[idx] = exp_reply;
  endtask

  // framing errors always get an answer and commands never do
  function automatic bit expects_reply(input logic [7:0] data, input bit bad);
    return bad || !data[7];
  endfunction

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
      errors++;
    end
  endtask

  // one bit period starting just after the rising edge
  task automatic drive_bit(input logic v);
    @(posedge clk_25mhz);
    #1;
    uart_rx_line = v;
    repeat (CLKS - 1) @(posedge clk_25mhz);
  endtask

  task automatic send_frame(input logic [7:0] data, input bit bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(!bad_stop);
    // line has to rise again so the next start bit shows an edge
    if (bad_stop) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic wait_replies(input string name, input int n, input int max_cycles);
    int waited = 0;
    while (echo_q.size() < n && waited < max_cycles) begin
      @(negedge clk_25mhz);
      waited++;
    end
    if (echo_q.size() < n) begin
      $display("Missing reply in test %s: only %0d of %0d bytes came back", name,
               echo_q.size(), n);
      errors++;
    end
  endtask

  task automatic expect_silence(input string name);
    repeat (QUIET) @(negedge clk_25mhz);
    while (echo_q.size() > 0) begin
      $display("Unexpected reply in test %s: byte 8'h%02h came back", name,
               echo_q.pop_front());
      errors++;
    end
    check_value({name, "_line"}, 8'h01, {7'b0, uart_tx_line});
  endtask

  // serial monitor sampling mid-bit on the falling clock edge
  initial begin
    logic [7:0] rx_byte;
    wait (mon_en);
    forever begin
      @(negedge clk_25mhz);
      if (uart_tx_line == 1'b0) begin
        repeat (CLKS / 2) @(negedge clk_25mhz);
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS) @(negedge clk_25mhz);
          rx_byte[i] = uart_tx_line;
        end
        repeat (CLKS) @(negedge clk_25mhz);
        if (uart_tx_line !== 1'b1) begin
          $display("Echoed frame carrying 8'h%02h ended with a low stop bit", rx_byte);
          errors++;
        end
        echo_q.push_back(rx_byte);
      end
    end
  end

  initial begin
    logic [7:0] ch;
    rst          = 1'b1;
    uart_rx_line = 1'b1;
    set_row(0, "echo_A",       8'h41, 1'b0, 8'h00, 8'h41);
    set_row(1, "echo_z",       8'h7a, 1'b0, 8'h00, 8'h7a);
    set_row(2, "op0_low",      8'h8a, 1'b0, 8'h0a, 8'h00);
    set_row(3, "op1_high",     8'ha5, 1'b0, 8'h5a, 8'h00);
    set_row(4, "op2_invert",   8'hc0, 1'b0, 8'ha5, 8'h00);
    set_row(5, "bad_stop_chr", 8'h55, 1'b1, 8'ha5, 8'h3f);
    // damaged command must not touch the leds
    set_row(6, "bad_stop_cmd", 8'h81, 1'b1, 8'ha5, 8'h3f);
    set_row(7, "op3_clear",    8'he0, 1'b0, 8'h00, 8'h00);
    // argument bit 4 is ignored
    set_row(8, "op0_arg_bit4", 8'h9f, 1'b0, 8'h0f, 8'h00);
    set_row(9, "echo_tilde",   8'h7e, 1'b0, 8'h0f, 8'h7e);

    repeat (8) @(posedge clk_25mhz);
    #1;
    rst = 1'b0;
    repeat (`UART_RST_STRETCH + 4) @(posedge clk_25mhz);
    mon_en = 1'b1;

    check_value("reset_leds", 8'h00, leds);
    expect_silence("reset_idle");

    for (int r = 0; r < N_ROWS; r++) begin
      send_frame(row_byte[r], row_bad[r]);
      if (expects_reply(row_byte[r], row_bad[r])) begin
        wait_replies(row_name[r], 1, 25 * CLKS);
        if (echo_q.size() > 0) begin
          check_value(row_name[r], row_reply[r], echo_q.pop_front());
        end
      end else begin
        expect_silence(row_name[r]);
      end
      check_value({row_name[r], "_leds"}, row_leds[r], leds);
    end

    // back to back characters, each one waits in the FIFO behind the echo still going out
    for (int n = 0; n < N_BURST; n++) begin
      for (int b = 0; b < 7; b++) begin
        lfsr  = lfsr_step(lfsr);
        ch[b] = lfsr[0];
      end
      ch[7] = 1'b0;
      burst_q.push_back(ch);
      send_frame(ch, 1'b0);
    end
    wait_replies("burst", N_BURST, 25 * CLKS);
    for (int n = 0; n < N_BURST; n++) begin
      if (echo_q.size() > 0) begin
        check_value($sformatf("burst_%0d", n), burst_q[n], echo_q.pop_front());
      end
    end
    expect_silence("burst_tail");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
    $display("errors: %0d", errors);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/uart_pkg.sv
hw/reset_gen.sv
hw/uart_rx.sv
hw/byte_fifo.sv
hw/uart_tx.sv
hw/cmd_dispatch.sv
hw/board_top.sv
sim/tb_board_top.sv
